// ==== design/tomasulo_cfg.svh ====
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// datapath word width
`define XLEN 32

// rob tag width, 3 bits addresses an 8 entry rob
`define ROB_TAG_W 3

// reservation station entries
`define RS_DEPTH 3

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

  // R-type layout, register-register alu ops
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_rtype_s;

  // I-type layout, register-immediate alu ops
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_itype_s;

  // one word, two readings; opcode sits in the same bits for both
  typedef union packed {
    rv_rtype_s r;
    rv_itype_s i;
  } rv_instr_u;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

// ==== design/core_pkg.sv ====
`include "tomasulo_cfg.svh"

package core_pkg;

  // functions the single alu can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare
    ALU_SLTU,  // unsigned compare
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_func_e;

  // names a rob slot, also the producer id seen on the cdb
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage

// ==== design/issue_decode.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module issue_decode (
  input  isa_pkg::rv_instr_u  instr,
  input  core_pkg::rob_tag_t  src2_tag,
  input  logic [`XLEN-1:0]    src2_value,
  input  logic                src2_ready,
  output core_pkg::alu_func_e func,
  output core_pkg::rob_tag_t  op2_tag,
  output logic [`XLEN-1:0]    op2_value,
  output logic                op2_ready
);

  logic [`XLEN-1:0] imm_sext;
  logic [`XLEN-1:0] shamt_ext;

  // funct3 picks the function, alt selects sub / sra
  function automatic core_pkg::alu_func_e f3_func(input logic [2:0] f3, input logic alt);
    case (f3)
      isa_pkg::F3_ADD_SUB: f3_func = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     f3_func = core_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     f3_func = core_pkg::ALU_SLT;
      isa_pkg::F3_SLTU:    f3_func = core_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:     f3_func = core_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: f3_func = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      isa_pkg::F3_OR:      f3_func = core_pkg::ALU_OR;
      default:             f3_func = core_pkg::ALU_AND;
    endcase
  endfunction

  assign imm_sext  = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign shamt_ext = `XLEN'(instr.i.imm12[4:0]);

  always_comb begin
    // pass operand 2 through unless the immediate replaces it
    func      = core_pkg::ALU_ADD;
    op2_tag   = src2_tag;
    op2_value = src2_value;
    op2_ready = src2_ready;
    case (instr.r.opcode)
      isa_pkg::OPC_OP: begin
        func = f3_func(instr.r.funct3, instr.r.funct7[5]);
      end
      isa_pkg::OPC_OP_IMM: begin
        // no subi exists, only the right shift uses the alt bit
        func      = f3_func(instr.i.funct3,
                            (instr.i.funct3 == isa_pkg::F3_SRL_SRA) && instr.i.imm12[10]);
        op2_ready = 1'b1;
        if (instr.i.funct3 == isa_pkg::F3_SLL || instr.i.funct3 == isa_pkg::F3_SRL_SRA) begin
          op2_value = shamt_ext;
        end else begin
          op2_value = imm_sext;
        end
      end
      default: ; // other opcodes fall back to add on the given operands
    endcase
  end

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module reservation_station (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                issue_valid,
  input  core_pkg::rob_tag_t  rob_tag,
  input  core_pkg::alu_func_e func,
  input  core_pkg::rob_tag_t  src1_tag,
  input  logic [`XLEN-1:0]    src1_value,
  input  logic                src1_ready,
  input  core_pkg::rob_tag_t  op2_tag,
  input  logic [`XLEN-1:0]    op2_value,
  input  logic                op2_ready,
  input  logic                alu_stall,
  input  logic                cdb_valid,
  input  core_pkg::rob_tag_t  cdb_tag,
  input  logic [`XLEN-1:0]    cdb_value,
  output logic                issue_ready,
  output logic                disp_valid,
  output core_pkg::alu_func_e disp_func,
  output logic [`XLEN-1:0]    disp_a,
  output logic [`XLEN-1:0]    disp_b,
  output core_pkg::rob_tag_t  disp_tag
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  // per-entry state
  logic [`RS_DEPTH-1:0] busy;
  logic [`RS_DEPTH-1:0] a_rdy;
  logic [`RS_DEPTH-1:0] b_rdy;
  core_pkg::alu_func_e  func_q [`RS_DEPTH];
  core_pkg::rob_tag_t   dest_q [`RS_DEPTH];
  core_pkg::rob_tag_t   a_tag  [`RS_DEPTH];
  core_pkg::rob_tag_t   b_tag  [`RS_DEPTH];
  logic [`XLEN-1:0]     a_val  [`RS_DEPTH];
  logic [`XLEN-1:0]     b_val  [`RS_DEPTH];

  logic [IDX_W-1:0]     free_idx;
  logic [IDX_W-1:0]     disp_idx;
  logic                 any_free;
  logic                 any_ready;
  logic                 issue_fire;
  logic                 a_hit_new;   // cdb carries src1 in the issue cycle
  logic                 b_hit_new;
  logic [`RS_DEPTH-1:0] a_wake;
  logic [`RS_DEPTH-1:0] b_wake;

  // lowest free slot for issue, lowest fully ready slot for dispatch
  always_comb begin
    free_idx  = '0;
    any_free  = 1'b0;
    disp_idx  = '0;
    any_ready = 1'b0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_idx = IDX_W'(i);
        any_free = 1'b1;
      end
      if (busy[i] && a_rdy[i] && b_rdy[i]) begin
        disp_idx  = IDX_W'(i);
        any_ready = 1'b1;
      end
    end
  end

  // tag match against the broadcast, waiting operands only
  always_comb begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      a_wake[i] = cdb_valid && busy[i] && !a_rdy[i] && (a_tag[i] == cdb_tag);
      b_wake[i] = cdb_valid && busy[i] && !b_rdy[i] && (b_tag[i] == cdb_tag);
    end
  end

  assign a_hit_new  = cdb_valid && !src1_ready && (src1_tag == cdb_tag);
  assign b_hit_new  = cdb_valid && !op2_ready && (op2_tag == cdb_tag);
  assign issue_ready = any_free;
  assign issue_fire  = issue_valid && any_free; // strobes while full are dropped

  assign disp_valid = any_ready && !alu_stall;
  assign disp_func  = func_q[disp_idx];
  assign disp_a     = a_val[disp_idx];
  assign disp_b     = b_val[disp_idx];
  assign disp_tag   = dest_q[disp_idx];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy  <= '0;
      a_rdy <= '0;
      b_rdy <= '0;
    end else begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (a_wake[i]) a_rdy[i] <= 1'b1;
        if (b_wake[i]) b_rdy[i] <= 1'b1;
      end
      if (disp_valid) busy[disp_idx] <= 1'b0;
      // issue slot is never the dispatch slot, it was free this cycle
      if (issue_fire) begin
        busy[free_idx]  <= 1'b1;
        a_rdy[free_idx] <= src1_ready || a_hit_new;
        b_rdy[free_idx] <= op2_ready || b_hit_new;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (a_wake[i]) a_val[i] <= cdb_value;
      if (b_wake[i]) b_val[i] <= cdb_value;
    end
    if (issue_fire) begin
      func_q[free_idx] <= func;
      dest_q[free_idx] <= rob_tag;
      a_tag[free_idx]  <= src1_tag;
      b_tag[free_idx]  <= op2_tag;
      a_val[free_idx]  <= a_hit_new ? cdb_value : src1_value;
      b_val[free_idx]  <= b_hit_new ? cdb_value : op2_value;
    end
  end

endmodule

// ==== design/alu_execute.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module alu_execute (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                disp_valid,
  input  core_pkg::alu_func_e disp_func,
  input  logic [`XLEN-1:0]    disp_a,
  input  logic [`XLEN-1:0]    disp_b,
  input  core_pkg::rob_tag_t  disp_tag,
  output logic                alu_valid,
  output core_pkg::rob_tag_t  alu_tag,
  output logic [`XLEN-1:0]    alu_value
);

  logic [4:0]       shamt;
  logic [`XLEN-1:0] result;

  assign shamt = disp_b[4:0]; // rv32 shifts ignore the upper bits

  always_comb begin
    case (disp_func)
      core_pkg::ALU_ADD:  result = disp_a + disp_b;
      core_pkg::ALU_SUB:  result = disp_a - disp_b;
      core_pkg::ALU_AND:  result = disp_a & disp_b;
      core_pkg::ALU_OR:   result = disp_a | disp_b;
      core_pkg::ALU_XOR:  result = disp_a ^ disp_b;
      core_pkg::ALU_SLT:  result = `XLEN'($signed(disp_a) < $signed(disp_b));
      core_pkg::ALU_SLTU: result = `XLEN'(disp_a < disp_b);
      core_pkg::ALU_SLL:  result = disp_a << shamt;
      core_pkg::ALU_SRL:  result = disp_a >> shamt;
      core_pkg::ALU_SRA:  result = $unsigned($signed(disp_a) >>> shamt);
      default:            result = disp_a + disp_b;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      alu_valid <= 1'b0;
    end else begin
      alu_valid <= disp_valid;
    end
  end

  // result and tag travel together, held until the next dispatch
  always_ff @(posedge clk_in) begin
    if (disp_valid) begin
      alu_tag   <= disp_tag;
      alu_value <= result;
    end
  end

endmodule

// ==== design/cdb_result.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module cdb_result (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               alu_valid,
  input  core_pkg::rob_tag_t alu_tag,
  input  logic [`XLEN-1:0]   alu_value,
  input  logic               ext_valid,
  input  core_pkg::rob_tag_t ext_tag,
  input  logic [`XLEN-1:0]   ext_value,
  output logic               alu_stall,
  output logic               cdb_valid,
  output core_pkg::rob_tag_t cdb_tag,
  output logic [`XLEN-1:0]   cdb_value
);

  // two entry alu result queue
  core_pkg::rob_tag_t q_tag [2];
  logic [`XLEN-1:0]   q_val [2];
  logic               rd_ptr;
  logic               wr_ptr;
  logic [1:0]         count;
  logic               q_empty;
  logic               push;
  logic               pop;

  assign q_empty   = (count == 2'd0);
  assign alu_stall = !q_empty;

  // load result wins the bus; an alu result bypasses only an empty queue
  assign pop  = !ext_valid && !q_empty;
  assign push = alu_valid && (ext_valid || !q_empty);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb_valid <= 1'b0;
      count     <= 2'd0;
      rd_ptr    <= 1'b0;
      wr_ptr    <= 1'b0;
    end else begin
      cdb_valid <= ext_valid || !q_empty || alu_valid;
      if (push) wr_ptr <= !wr_ptr;
      if (pop) rd_ptr <= !rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_in) begin
    if (ext_valid) begin
      cdb_tag   <= ext_tag;
      cdb_value <= ext_value;
    end else if (!q_empty) begin
      cdb_tag   <= q_tag[rd_ptr];
      cdb_value <= q_val[rd_ptr];
    end else if (alu_valid) begin
      cdb_tag   <= alu_tag;
      cdb_value <= alu_value;
    end
    if (push) begin
      q_tag[wr_ptr] <= alu_tag;
      q_val[wr_ptr] <= alu_value;
    end
  end

endmodule

// ==== design/alu_cluster.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module alu_cluster (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               issue_valid,
  input  isa_pkg::rv_instr_u instr,
  input  core_pkg::rob_tag_t rob_tag,
  input  core_pkg::rob_tag_t src1_tag,
  input  logic [`XLEN-1:0]   src1_value,
  input  logic               src1_ready,
  input  core_pkg::rob_tag_t src2_tag,
  input  logic [`XLEN-1:0]   src2_value,
  input  logic               src2_ready,
  input  logic               ext_valid,
  input  core_pkg::rob_tag_t ext_tag,
  input  logic [`XLEN-1:0]   ext_value,
  output logic               issue_ready,
  output logic               cdb_valid,
  output core_pkg::rob_tag_t cdb_tag,
  output logic [`XLEN-1:0]   cdb_value
);

  // decode to station
  core_pkg::alu_func_e func;
  core_pkg::rob_tag_t  op2_tag;
  logic [`XLEN-1:0]    op2_value;
  logic                op2_ready;

  // station to alu
  logic                disp_valid;
  core_pkg::alu_func_e disp_func;
  logic [`XLEN-1:0]    disp_a;
  logic [`XLEN-1:0]    disp_b;
  core_pkg::rob_tag_t  disp_tag;

  // alu to cdb driver
  logic                alu_valid;
  core_pkg::rob_tag_t  alu_tag;
  logic [`XLEN-1:0]    alu_value;
  logic                alu_stall;

  issue_decode u_decode (
    .instr      (instr),
    .src2_tag   (src2_tag),
    .src2_value (src2_value),
    .src2_ready (src2_ready),
    .func       (func),
    .op2_tag    (op2_tag),
    .op2_value  (op2_value),
    .op2_ready  (op2_ready)
  );

  reservation_station u_rs (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .rob_tag     (rob_tag),
    .func        (func),
    .src1_tag    (src1_tag),
    .src1_value  (src1_value),
    .src1_ready  (src1_ready),
    .op2_tag     (op2_tag),
    .op2_value   (op2_value),
    .op2_ready   (op2_ready),
    .alu_stall   (alu_stall),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value),
    .issue_ready (issue_ready),
    .disp_valid  (disp_valid),
    .disp_func   (disp_func),
    .disp_a      (disp_a),
    .disp_b      (disp_b),
    .disp_tag    (disp_tag)
  );

  alu_execute u_alu (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .disp_valid (disp_valid),
    .disp_func  (disp_func),
    .disp_a     (disp_a),
    .disp_b     (disp_b),
    .disp_tag   (disp_tag),
    .alu_valid  (alu_valid),
    .alu_tag    (alu_tag),
    .alu_value  (alu_value)
  );

  cdb_result u_cdb (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .alu_valid (alu_valid),
    .alu_tag   (alu_tag),
    .alu_value (alu_value),
    .ext_valid (ext_valid),
    .ext_tag   (ext_tag),
    .ext_value (ext_value),
    .alu_stall (alu_stall),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk_in
);

  initial begin
    clk_in = 1'b0;
    forever #(PERIOD / 2) clk_in = ~clk_in; // 50% duty
  end

endmodule

// ==== testbench/alu_cluster_chk.sv ====
`timescale 1ns/1ps

module alu_cluster_chk (
  input logic               clk_in,
  input logic               rst_in,
  input logic               issue_ready,
  input logic               alu_valid,
  input logic               alu_stall,
  input logic               ext_valid,
  input core_pkg::rob_tag_t ext_tag,
  input logic               cdb_valid,
  input core_pkg::rob_tag_t cdb_tag
);

  int fail_count = 0;

  // the same tag twice in a row is a duplicate unless the load unit just reissued it
  cdb_no_repeat: assert property (@(posedge clk_in) disable iff (rst_in)
    cdb_valid && $past(cdb_valid) |->
      (cdb_tag != $past(cdb_tag)) || ($past(ext_valid) && ($past(ext_tag) == cdb_tag)))
    else begin
      $error("cdb carried tag %0d on two consecutive cycles", cdb_tag);
      fail_count++;
    end

  // no alu result follows a cycle in which the queue held one
  no_dispatch_on_stall: assert property (@(posedge clk_in) disable iff (rst_in)
    alu_stall |=> !alu_valid)
    else begin
      $error("alu result arrived although the result queue stalled dispatch");
      fail_count++;
    end

  ready_after_reset: assert property (@(posedge clk_in)
    $fell(rst_in) |-> issue_ready && !cdb_valid)
    else begin
      $error("station not empty or cdb busy right after reset");
      fail_count++;
    end

endmodule

bind alu_cluster alu_cluster_chk u_chk (
  .clk_in      (clk_in),
  .rst_in      (rst_in),
  .issue_ready (issue_ready),
  .alu_valid   (alu_valid),
  .alu_stall   (alu_stall),
  .ext_valid   (ext_valid),
  .ext_tag     (ext_tag),
  .cdb_valid   (cdb_valid),
  .cdb_tag     (cdb_tag)
);

// ==== testbench/tb_alu_cluster.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module tb_alu_cluster;

  localparam int NUM_TESTS   = 5;
  localparam int OPS         = 60;  // issues per random test
  localparam int NTAGS       = 1 << `ROB_TAG_W;
  localparam int WATCHDOG_NS = NUM_TESTS * OPS * 40 * 20;

  // model state of one rob tag
  localparam int FREE      = 0;
  localparam int ALU       = 1;
  localparam int LOAD      = 2;  // load value chosen but not yet strobed
  localparam int LOAD_SENT = 3;

  logic               clk_in;
  logic               rst_in;
  logic               issue_valid;
  isa_pkg::rv_instr_u instr;
  core_pkg::rob_tag_t rob_tag;
  core_pkg::rob_tag_t src1_tag;
  logic [`XLEN-1:0]   src1_value;
  logic               src1_ready;
  core_pkg::rob_tag_t src2_tag;
  logic [`XLEN-1:0]   src2_value;
  logic               src2_ready;
  logic               ext_valid;
  core_pkg::rob_tag_t ext_tag;
  logic [`XLEN-1:0]   ext_value;
  logic               issue_ready;
  logic               cdb_valid;
  core_pkg::rob_tag_t cdb_tag;
  logic [`XLEN-1:0]   cdb_value;

  int               tag_state [NTAGS];
  logic [`XLEN-1:0] tag_value [NTAGS];  // expected cdb value per tag
  int  errors;
  int  checks;
  int  results;
  int  drops;
  int  tests_failed;
  int  issued;
  bit  last_accepted;
  bit  expect_drop;
  bit  expect_full;
  bit  ext_pend;
  core_pkg::rob_tag_t ext_pend_tag;
  int  issue_pct;
  int  dep_pct;
  int  load_pct;
  int  ext_pct;
  int  fixed_func;  // -1 picks a random function

  tb_clock #(.PERIOD(20)) u_clk (.clk_in(clk_in));

  alu_cluster u_dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .instr       (instr),
    .rob_tag     (rob_tag),
    .src1_tag    (src1_tag),
    .src1_value  (src1_value),
    .src1_ready  (src1_ready),
    .src2_tag    (src2_tag),
    .src2_value  (src2_value),
    .src2_ready  (src2_ready),
    .ext_valid   (ext_valid),
    .ext_tag     (ext_tag),
    .ext_value   (ext_value),
    .issue_ready (issue_ready),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value)
  );

  function automatic logic [`XLEN-1:0] alu_model(input core_pkg::alu_func_e f,
                                                input logic [`XLEN-1:0] a,
                                                input logic [`XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f)
      core_pkg::ALU_SUB:  return a - b;
      core_pkg::ALU_AND:  return a & b;
      core_pkg::ALU_OR:   return a | b;
      core_pkg::ALU_XOR:  return a ^ b;
      core_pkg::ALU_SLT:  return `XLEN'((a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b));
      core_pkg::ALU_SLTU: return `XLEN'(a < b);
      core_pkg::ALU_SLL:  return a << sh;
      core_pkg::ALU_SRL:  return a >> sh;
      core_pkg::ALU_SRA:  return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
      default:            return a + b;
    endcase
  endfunction

  // edge values show up often so slt/sltu/sra meet sign boundaries
  function automatic logic [`XLEN-1:0] rand_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return `XLEN'(1);
      2:       return '1;
      3:       return {1'b1, {(`XLEN-1){1'b0}}};
      4:       return {1'b0, {(`XLEN-1){1'b1}}};
      default: return $urandom;
    endcase
  endfunction

  function automatic isa_pkg::rv_instr_u make_instr(input core_pkg::alu_func_e f,
                                                    input bit use_imm);
    isa_pkg::rv_instr_u w;
    logic [2:0] f3;
    bit alt;
    w = $urandom;  // register fields and immediate stay random
    case (f)
      core_pkg::ALU_SLL:  f3 = isa_pkg::F3_SLL;
      core_pkg::ALU_SLT:  f3 = isa_pkg::F3_SLT;
      core_pkg::ALU_SLTU: f3 = isa_pkg::F3_SLTU;
      core_pkg::ALU_XOR:  f3 = isa_pkg::F3_XOR;
      core_pkg::ALU_SRL, core_pkg::ALU_SRA: f3 = isa_pkg::F3_SRL_SRA;
      core_pkg::ALU_OR:   f3 = isa_pkg::F3_OR;
      core_pkg::ALU_AND:  f3 = isa_pkg::F3_AND;
      default:            f3 = isa_pkg::F3_ADD_SUB;
    endcase
    alt = (f == core_pkg::ALU_SUB) || (f == core_pkg::ALU_SRA);
    if (use_imm) begin
      w.i.opcode = isa_pkg::OPC_OP_IMM;
      w.i.funct3 = f3;
      if (f3 == isa_pkg::F3_SLL || f3 == isa_pkg::F3_SRL_SRA) begin
        w.i.imm12[11:5] = {1'b0, alt, 5'b0};
      end
    end else begin
      w.r.opcode = isa_pkg::OPC_OP;
      w.r.funct3 = f3;
      w.r.funct7 = alt ? 7'b0100000 : 7'b0000000;
    end
    return w;
  endfunction

  // want is a state, or -1 for any pending tag; random start spreads tags
  function automatic int pick_tag(input int want);
    int start;
    int t;
    start = $urandom % NTAGS;
    for (int k = 0; k < NTAGS; k++) begin
      t = (start + k) % NTAGS;
      if ((want < 0) ? (tag_state[t] != FREE) : (tag_state[t] == want)) return t;
    end
    return -1;
  endfunction

  function automatic int count_state(input int s);
    int n;
    n = 0;
    for (int t = 0; t < NTAGS; t++) begin
      if (tag_state[t] == s) n++;
    end
    return n;
  endfunction

  task automatic send_issue();
    int t;
    int p;
    core_pkg::alu_func_e f;
    bit use_imm;
    isa_pkg::rv_instr_u w;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    t = pick_tag(FREE);
    if (t < 0) return;
    f = core_pkg::alu_func_e'((fixed_func >= 0) ? fixed_func : $urandom % 10);
    use_imm = (f != core_pkg::ALU_SUB) && ($urandom % 2);
    w = make_instr(f, use_imm);
    a = rand_operand();
    p = ($urandom % 100 < dep_pct) ? pick_tag(-1) : -1;
    src1_ready <= (p < 0);
    src1_tag   <= core_pkg::rob_tag_t'((p < 0) ? $urandom : p);
    src1_value <= (p < 0) ? a : $urandom;  // value ignored while waiting
    if (p >= 0) a = tag_value[p];
    b = rand_operand();
    p = ($urandom % 100 < dep_pct) ? pick_tag(-1) : -1;
    src2_ready <= (p < 0);
    src2_tag   <= core_pkg::rob_tag_t'((p < 0) ? $urandom : p);
    src2_value <= (p < 0) ? b : $urandom;
    if (p >= 0) b = tag_value[p];
    // immediate forms ignore src2 even when it waits
    if (use_imm && w.i.funct3 inside {isa_pkg::F3_SLL, isa_pkg::F3_SRL_SRA}) begin
      b = `XLEN'(w.i.imm12) % 32;  // shift amount is the low five bits
    end else if (use_imm) begin
      b = `XLEN'($signed(w.i.imm12));
    end
    tag_state[t] = ALU;
    tag_value[t] = alu_model(f, a, b);
    issue_valid <= 1'b1;
    instr       <= w;
    rob_tag     <= core_pkg::rob_tag_t'(t);
    issued++;
  endtask

  // outputs as they stood during the cycle that just ended
  task automatic observe();
    last_accepted = issue_valid && issue_ready;
    if (issue_valid && !issue_ready) begin
      tag_state[rob_tag] = FREE;
      drops++;
      if (!expect_drop) begin
        $display("issue of tag %0d was dropped although the station had room", rob_tag);
        errors++;
      end
    end
    if (expect_full) begin
      checks++;
      if (issue_ready !== 1'b0) begin
        $display("** Error: issue_ready with a full station: got 0x%h expected 0x0", issue_ready);
        errors++;
      end
    end
    if (ext_pend) begin
      checks++;
      if (cdb_valid !== 1'b1 || cdb_tag !== ext_pend_tag) begin
        $display("** Error: cdb_tag after ext_valid: got 0x%h (cdb_valid 0x%h) expected 0x%h",
                 cdb_tag, cdb_valid, ext_pend_tag);
        errors++;
      end
    end
    ext_pend     = ext_valid;
    ext_pend_tag = ext_tag;
    if (cdb_valid) begin
      checks++;
      if (tag_state[cdb_tag] == FREE) begin
        $display("cdb carried tag %0d which has no pending instruction or load", cdb_tag);
        errors++;
      end else if (cdb_value !== tag_value[cdb_tag]) begin
        $display("** Error: cdb_value for cdb_tag 0x%h: got 0x%h expected 0x%h",
                 cdb_tag, cdb_value, tag_value[cdb_tag]);
        errors++;
      end
      tag_state[cdb_tag] = FREE;
      results++;
    end
  endtask

  task automatic drive_inputs();
    int t;
    issue_valid <= 1'b0;
    ext_valid   <= 1'b0;
    if ($urandom % 100 < ext_pct) begin
      t = pick_tag(LOAD);
      if (t >= 0) begin
        ext_valid <= 1'b1;
        ext_tag   <= core_pkg::rob_tag_t'(t);
        ext_value <= tag_value[t];
        tag_state[t] = LOAD_SENT;
      end
    end
    if ($urandom % 100 < load_pct && count_state(LOAD) + count_state(LOAD_SENT) < 2) begin
      t = pick_tag(FREE);
      if (t >= 0) begin
        tag_state[t] = LOAD;
        tag_value[t] = rand_operand();
      end
    end
    // room is certain only when no issue was written at this edge
    if ($urandom % 100 < issue_pct && issue_ready && !last_accepted) send_issue();
  endtask

  task automatic run_cycle();
    @(posedge clk_in);
    observe();
    drive_inputs();
  endtask

  task automatic run_issues(input int n);
    issued = 0;
    while (issued < n) run_cycle();
  endtask

  task automatic drain();
    int cyc;
    issue_pct = 0;
    load_pct  = 0;
    ext_pct   = 50;
    cyc = 0;
    while (count_state(FREE) != NTAGS && cyc < 400) begin
      run_cycle();
      cyc++;
    end
    if (cyc >= 400) begin
      $display("%0d results never reached the cdb", NTAGS - count_state(FREE));
      errors++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %-18s passed", name);
    end else begin
      $display("test %-18s failed with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int e;
    int t;
    int r;
    int cyc;
    void'($urandom(10));
    rst_in      = 1'b1;
    issue_valid = 1'b0;
    instr       = '0;
    rob_tag     = '0;
    src1_tag    = '0;
    src1_value  = '0;
    src1_ready  = 1'b0;
    src2_tag    = '0;
    src2_value  = '0;
    src2_ready  = 1'b0;
    ext_valid   = 1'b0;
    ext_tag     = '0;
    ext_value   = '0;
    for (int k = 0; k < NTAGS; k++) tag_state[k] = FREE;
    fixed_func = -1;
    repeat (2) @(posedge clk_in);
    rst_in <= 1'b0;

    e = errors;
    repeat (3) begin
      @(posedge clk_in);
      checks++;
      if (cdb_valid !== 1'b0 || issue_ready !== 1'b1) begin
        $display("** Error: after reset cdb_valid 0x%h issue_ready 0x%h, expected 0x0 and 0x1",
                 cdb_valid, issue_ready);
        errors++;
      end
    end
    report("reset state", e);

    e = errors;
    issue_pct = 100;
    for (int k = 0; k < OPS; k++) begin
      fixed_func = k % 10;  // every function in turn
      run_issues(1);
    end
    fixed_func = -1;
    drain();
    report("alu functions", e);

    e = errors;
    issue_pct = 70;
    dep_pct   = 60;
    load_pct  = 30;
    ext_pct   = 20;
    run_issues(OPS);
    drain();
    report("dependency wake-up", e);

    e = errors;
    issue_pct = 100;
    dep_pct   = 20;
    load_pct  = 60;
    ext_pct   = 80;
    run_issues(OPS);
    drain();
    report("external priority", e);

    // three entries all wait on loads that are held back
    e = errors;
    ext_pct  = 0;
    load_pct = 0;
    dep_pct  = 100;
    repeat (3) begin
      t = pick_tag(FREE);
      tag_state[t] = LOAD;
      tag_value[t] = rand_operand();
    end
    issue_pct = 100;
    run_issues(3);
    issue_pct = 0;
    run_cycle();
    expect_full = 1'b1;
    repeat (4) run_cycle();
    expect_drop = 1'b1;
    r = drops;
    run_cycle();
    send_issue();
    run_cycle();
    expect_drop = 1'b0;
    if (drops == r) begin
      $display("issue strobe sent while issue_ready was low was not dropped");
      errors++;
    end
    expect_full = 1'b0;
    ext_pct = 100;
    r = results;
    cyc = 0;
    do begin
      run_cycle();
      cyc++;
    end while (!issue_ready && cyc < 30);
    if (!issue_ready) begin
      $display("issue_ready stayed low %0d cycles after the loads were released", cyc);
      errors++;
    end else if (results == r) begin
      $display("issue_ready rose before any result reached the cdb");
      errors++;
    end
    drain();
    report("station full", e);

    errors += u_dut.u_chk.fail_count;
    $display("tests %0d, failed %0d, checks %0d, cdb results %0d, drops %0d, errors %0d",
             NUM_TESTS, tests_failed, checks, results, drops, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/issue_decode.sv
design/reservation_station.sv
design/alu_execute.sv
design/cdb_result.sv
design/alu_cluster.sv
testbench/tb_clock.sv
testbench/alu_cluster_chk.sv
testbench/tb_alu_cluster.sv

// ==== Bender.yml ====
package:
  name: alu_cluster

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/core_pkg.sv
      - design/issue_decode.sv
      - design/reservation_station.sv
      - design/alu_execute.sv
      - design/cdb_result.sv
      - design/alu_cluster.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock.sv
      - testbench/alu_cluster_chk.sv
      - testbench/tb_alu_cluster.sv
